// ==== cpu_pkg.sv ====
package cpu_pkg;

	// Decode lanes, one per instruction slot of a 16-byte response
	localparam int num_lanes = 4;

	// Queue entries per lane, also the credits each lane starts with
	localparam int lane_depth = 2;

	// Credit counter and lane occupancy width
	localparam int credit_w = 2;

	// L1.5 return types
	localparam logic [3:0] rt_load_ret = 4'b0000;
	localparam logic [3:0] rt_wakeup = 4'b0111;

	// RV32I major opcodes
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_store = 7'b0100011;

	// funct3 for ADD and ADDI, and for word loads and stores
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_word = 3'b010;

	// Operations handed from a lane to the retire unit
	localparam logic [2:0] op_nop = 3'd0;
	localparam logic [2:0] op_add = 3'd1;
	localparam logic [2:0] op_addi = 3'd2;
	localparam logic [2:0] op_lw = 3'd3;
	localparam logic [2:0] op_sw = 3'd4;

	// Data memory words
	localparam int dmem_words = 16;

	// Fetch FSM states
	localparam logic [1:0] fs_wake = 2'd0;
	localparam logic [1:0] fs_req = 2'd1;
	localparam logic [1:0] fs_resp = 2'd2;
	localparam logic [1:0] fs_disp = 2'd3;

	// One instruction word, three ways of reading it
	typedef union packed
	{
		// Register-register
		struct packed
		{
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		// Immediate and loads
		struct packed
		{
			logic [11:0] imm12;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i;
		// Stores, immediate split around rs2 and rs1
		struct packed
		{
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
	} instr_u;

endpackage

// ==== decode_lane.sv ====
module decode_lane
(
	input logic clk,
	input logic nrst,
	issue_if.lane issue,
	retire_if.lane drain
);

	cpu_pkg::instr_u q_instr [cpu_pkg::lane_depth];
	logic [31:0] q_pc [cpu_pkg::lane_depth];
	logic [$clog2(cpu_pkg::lane_depth)-1:0] wr_ptr;
	logic [$clog2(cpu_pkg::lane_depth)-1:0] rd_ptr;
	// Occupancy, never above the credits handed out
	logic [cpu_pkg::credit_w-1:0] count;
	cpu_pkg::instr_u head;

	// Freed entry goes straight back as a credit
	assign issue.credit = drain.pop;

	assign head = q_instr[rd_ptr];
	assign drain.head_valid = (count != '0);
	assign drain.pc = q_pc[rd_ptr];
	assign drain.rd = head.r.rd;
	assign drain.rs1 = head.r.rs1;
	assign drain.rs2 = head.r.rs2;

	// Head decode, view chosen by opcode
	always_comb
	begin
		drain.op = cpu_pkg::op_nop;
		drain.imm = {{20{head.i.imm12[11]}}, head.i.imm12};
		case (head.r.opcode)
			cpu_pkg::opc_op:
				// Only plain ADD, SUB and friends fall to nop
				if (head.r.funct7 == 7'd0 && head.r.funct3 == cpu_pkg::f3_add)
					drain.op = cpu_pkg::op_add;
			cpu_pkg::opc_op_imm:
				if (head.i.funct3 == cpu_pkg::f3_add)
					drain.op = cpu_pkg::op_addi;
			cpu_pkg::opc_load:
				if (head.i.funct3 == cpu_pkg::f3_word)
					drain.op = cpu_pkg::op_lw;
			cpu_pkg::opc_store:
			begin
				// Store offset is split across two fields
				drain.imm = {{20{head.s.imm_hi[6]}}, head.s.imm_hi, head.s.imm_lo};
				if (head.s.funct3 == cpu_pkg::f3_word)
					drain.op = cpu_pkg::op_sw;
			end
			default:
				drain.op = cpu_pkg::op_nop;
		endcase
	end

	// Queue storage
	always_ff @(posedge clk)
	begin
		if (issue.valid)
		begin
			q_instr[wr_ptr] <= issue.instr;
			q_pc[wr_ptr] <= issue.pc;
		end
	end

	// Pointers and occupancy
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (issue.valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (drain.pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({issue.valid, drain.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== fetch_transducer.sv ====
module fetch_transducer
(
	input logic clk,
	input logic nrst,
	input logic l15_transducer_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic [63:0] l15_transducer_data_0,
	input logic [63:0] l15_transducer_data_1,
	input logic [3:0] l15_transducer_returntype,
	output logic transducer_l15_val,
	output logic [31:0] transducer_l15_address,
	output logic transducer_l15_req_ack,
	issue_if.disp lanes [cpu_pkg::num_lanes]
);

	logic [1:0] state;
	// Slot being dispatched, equal to its target lane
	logic [$clog2(cpu_pkg::num_lanes)-1:0] slot_idx;
	logic [cpu_pkg::credit_w-1:0] credit_cnt [cpu_pkg::num_lanes];
	cpu_pkg::instr_u slot_buf [cpu_pkg::num_lanes];
	logic [127:0] resp_line;
	logic load_slots;
	logic issue_go;
	logic [cpu_pkg::num_lanes-1:0] issue_vec;
	logic [cpu_pkg::num_lanes-1:0] credit_in;

	// Slot order is low then high word of data_0, then of data_1
	assign resp_line = {l15_transducer_data_1, l15_transducer_data_0};

	// Load response seen while the buffer is empty, not yet acked
	assign load_slots = (state == cpu_pkg::fs_resp) && l15_transducer_val
		&& !transducer_l15_req_ack
		&& (l15_transducer_returntype == cpu_pkg::rt_load_ret);

	// Dispatch only into a lane that still has credit
	assign issue_go = (state == cpu_pkg::fs_disp) && (credit_cnt[slot_idx] != '0);

	for (genvar g = 0; g < cpu_pkg::num_lanes; g++)
	begin : lane_port
		assign issue_vec[g] = issue_go && (slot_idx == g);
		assign lanes[g].valid = issue_vec[g];
		// Payload goes to every lane, only the strobed one takes it
		assign lanes[g].instr = slot_buf[slot_idx];
		assign lanes[g].pc = transducer_l15_address + (32'(slot_idx) << 2);
		assign credit_in[g] = lanes[g].credit;
	end

	// Instruction slots, filled in the ack cycle
	always_ff @(posedge clk)
	begin
		if (load_slots)
		begin
			for (int i = 0; i < cpu_pkg::num_lanes; i++)
				slot_buf[i] <= resp_line[32*i +: 32];
		end
	end

	// Per-lane credits, down on issue and up on a credit pulse
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < cpu_pkg::num_lanes; i++)
				credit_cnt[i] <= cpu_pkg::lane_depth[cpu_pkg::credit_w-1:0];
		end
		else
		begin
			for (int i = 0; i < cpu_pkg::num_lanes; i++)
			begin
				case ({credit_in[i], issue_vec[i]})
					2'b10: credit_cnt[i] <= credit_cnt[i] + 1'b1;
					2'b01: credit_cnt[i] <= credit_cnt[i] - 1'b1;
					default: credit_cnt[i] <= credit_cnt[i];
				endcase
			end
		end
	end

	// Request and response FSM
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			state <= cpu_pkg::fs_wake;
			slot_idx <= '0;
			transducer_l15_val <= 1'b0;
			transducer_l15_address <= '0;
			transducer_l15_req_ack <= 1'b0;
		end
		else
		begin
			// Ack is a single-cycle pulse
			transducer_l15_req_ack <= 1'b0;
			case (state)
				cpu_pkg::fs_wake:
				begin
					// Cycle after the wake-up ack, raise the first request at 0
					if (transducer_l15_req_ack)
					begin
						transducer_l15_val <= 1'b1;
						transducer_l15_address <= '0;
						state <= cpu_pkg::fs_req;
					end
					else if (l15_transducer_val
						&& (l15_transducer_returntype == cpu_pkg::rt_wakeup))
						transducer_l15_req_ack <= 1'b1;
				end
				cpu_pkg::fs_req:
				begin
					// Held until both acks land together
					if (l15_transducer_ack && l15_transducer_header_ack)
					begin
						transducer_l15_val <= 1'b0;
						state <= cpu_pkg::fs_resp;
					end
				end
				cpu_pkg::fs_resp:
				begin
					// Any response gets acked, a stray type is dropped
					if (l15_transducer_val && !transducer_l15_req_ack)
					begin
						transducer_l15_req_ack <= 1'b1;
						if (load_slots)
						begin
							slot_idx <= '0;
							state <= cpu_pkg::fs_disp;
						end
					end
				end
				default:
				begin
					if (issue_go)
					begin
						slot_idx <= slot_idx + 1'b1;
						// Last slot gone, ask for the next line
						if (slot_idx == $bits(slot_idx)'(cpu_pkg::num_lanes - 1))
						begin
							transducer_l15_val <= 1'b1;
							transducer_l15_address <= transducer_l15_address + 32'd16;
							state <= cpu_pkg::fs_req;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== issue_if.sv ====
// Transducer to one decode lane
interface issue_if;

	// One-cycle write strobe into the lane queue
	logic valid;
	// Raw instruction word from its response slot
	cpu_pkg::instr_u instr;
	// Line address plus four times the slot
	logic [31:0] pc;
	// One-cycle pulse back when the lane frees an entry
	logic credit;

	// Transducer side
	modport disp
	(
		output valid,
		output instr,
		output pc,
		input credit
	);

	// Lane side
	modport lane
	(
		input valid,
		input instr,
		input pc,
		output credit
	);

endinterface

// ==== list.f ====
cpu_pkg.sv
issue_if.sv
retire_if.sv
fetch_transducer.sv
decode_lane.sv
retire_unit.sv
piton_core.sv
piton_core_props.sv
tb_piton_core.sv

// ==== piton_core.sv ====
module piton_core
(
	input logic clk,
	input logic nrst,
	input logic l15_transducer_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic [63:0] l15_transducer_data_0,
	input logic [63:0] l15_transducer_data_1,
	input logic [3:0] l15_transducer_returntype,
	output logic transducer_l15_val,
	output logic [31:0] transducer_l15_address,
	output logic transducer_l15_req_ack,
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [31:0] wb_data
);

	// One issue and one drain bus per lane
	issue_if issue_bus [cpu_pkg::num_lanes] ();
	retire_if retire_bus [cpu_pkg::num_lanes] ();

	// L1.5 side and slot dispatch
	fetch_transducer fetch_inst
	(
		.clk(clk),
		.nrst(nrst),
		.l15_transducer_val(l15_transducer_val),
		.l15_transducer_ack(l15_transducer_ack),
		.l15_transducer_header_ack(l15_transducer_header_ack),
		.l15_transducer_data_0(l15_transducer_data_0),
		.l15_transducer_data_1(l15_transducer_data_1),
		.l15_transducer_returntype(l15_transducer_returntype),
		.transducer_l15_val(transducer_l15_val),
		.transducer_l15_address(transducer_l15_address),
		.transducer_l15_req_ack(transducer_l15_req_ack),
		.lanes(issue_bus)
	);

	// Identical lanes, slot g lands in lane g
	for (genvar g = 0; g < cpu_pkg::num_lanes; g++)
	begin : lane_gen
		decode_lane lane_inst
		(
			.clk(clk),
			.nrst(nrst),
			.issue(issue_bus[g]),
			.drain(retire_bus[g])
		);
	end

	// In-order drain and commit trace
	retire_unit retire_inst
	(
		.clk(clk),
		.nrst(nrst),
		.lanes(retire_bus),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

endmodule

// ==== piton_core_golden.txt ====
# B w0 w1 w2 w3 : one L1.5 response, instruction words in program order (hex)
# C rd data     : one expected commit on the trace, in order (hex)
# addi x1,x0,5 / addi x2,x1,7 / add x3,x1,x2 / addi x0,x1,1
B 00500093 00708113 002081b3 00108013
C 01 00000005
C 02 0000000c
C 03 00000011
# sw x3,8(x1) / lw x4,8(x1) / add x5,x4,x3 / nop word
B 0030a423 0080a203 003202b3 00000000
C 04 00000011
C 05 00000022
# addi x6,x0,-3 / add x7,x6,x5 / sub x8,x7,x1 / addi x8,x7,100
B ffd00313 005303b3 40138433 06438413
C 06 fffffffd
C 07 0000001f
C 08 00000083
# sw x8,-4(x6) / lw x9,56(x0) / add x10,x9,x9 / lw x0,56(x0)
B fe832e23 03802483 00948533 03802003
C 09 00000083
C 0a 00000106

// ==== piton_core_props.sv ====
module piton_core_props
(
	input logic clk,
	input logic nrst,
	input logic l15_transducer_val,
	input logic l15_transducer_ack,
	input logic l15_transducer_header_ack,
	input logic transducer_l15_val,
	input logic [31:0] transducer_l15_address,
	input logic transducer_l15_req_ack,
	input logic [cpu_pkg::num_lanes-1:0] credit_in,
	input logic [cpu_pkg::credit_w-1:0] credit_cnt [cpu_pkg::num_lanes]
);

	timeunit 1ns;
	timeprecision 1ns;

	// Request held with its address until both acks
	assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_val && !(l15_transducer_ack && l15_transducer_header_ack)
		|=> transducer_l15_val && $stable(transducer_l15_address))
		else $error("request dropped or changed before it was accepted");

	// Ack only answers a held response
	assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack |-> l15_transducer_val)
		else $error("req_ack raised with no response pending");

	// Full counter means an empty lane, nothing there to hand back
	for (genvar g = 0; g < cpu_pkg::num_lanes; g++)
	begin : lane_chk
		assert property (@(posedge clk) disable iff (!nrst)
			credit_in[g] |-> credit_cnt[g] != cpu_pkg::lane_depth[cpu_pkg::credit_w-1:0])
			else $error("lane %0d returned a credit it was never given", g);
	end

endmodule

bind fetch_transducer piton_core_props props_inst
(
	.clk(clk),
	.nrst(nrst),
	.l15_transducer_val(l15_transducer_val),
	.l15_transducer_ack(l15_transducer_ack),
	.l15_transducer_header_ack(l15_transducer_header_ack),
	.transducer_l15_val(transducer_l15_val),
	.transducer_l15_address(transducer_l15_address),
	.transducer_l15_req_ack(transducer_l15_req_ack),
	.credit_in(credit_in),
	.credit_cnt(credit_cnt)
);

// ==== retire_if.sv ====
// Decode lane to the retire unit
interface retire_if;

	// Queue head holds an instruction
	logic head_valid;
	// Decoded operation of the head
	logic [2:0] op;
	// Register fields
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	// Immediate, already sign-extended
	logic [31:0] imm;
	// Address the head was fetched from
	logic [31:0] pc;
	// Retire takes the head this cycle
	logic pop;

	// Lane side
	modport lane
	(
		output head_valid,
		output op,
		output rd,
		output rs1,
		output rs2,
		output imm,
		output pc,
		input pop
	);

	// Retire side
	modport ret
	(
		input head_valid,
		input op,
		input rd,
		input rs1,
		input rs2,
		input imm,
		input pc,
		output pop
	);

endinterface

// ==== retire_unit.sv ====
module retire_unit
(
	input logic clk,
	input logic nrst,
	retire_if.ret lanes [cpu_pkg::num_lanes],
	output logic wb_valid,
	output logic [4:0] wb_rd,
	output logic [31:0] wb_data
);

	logic [$clog2(cpu_pkg::num_lanes)-1:0] ptr;
	logic hv [cpu_pkg::num_lanes];
	logic [2:0] op_v [cpu_pkg::num_lanes];
	logic [4:0] rd_v [cpu_pkg::num_lanes];
	logic [4:0] rs1_v [cpu_pkg::num_lanes];
	logic [4:0] rs2_v [cpu_pkg::num_lanes];
	logic [31:0] imm_v [cpu_pkg::num_lanes];
	logic [31:0] regs [32];
	logic [31:0] dmem [cpu_pkg::dmem_words];
	logic pop_go;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic [31:0] mem_addr;
	logic [$clog2(cpu_pkg::dmem_words)-1:0] dmem_idx;
	logic [31:0] result;
	logic writes_rd;

	// Flatten the lane buses so the pointer can pick one
	for (genvar g = 0; g < cpu_pkg::num_lanes; g++)
	begin : lane_tap
		assign hv[g] = lanes[g].head_valid;
		assign op_v[g] = lanes[g].op;
		assign rd_v[g] = lanes[g].rd;
		assign rs1_v[g] = lanes[g].rs1;
		assign rs2_v[g] = lanes[g].rs2;
		assign imm_v[g] = lanes[g].imm;
		assign lanes[g].pop = pop_go && (ptr == g);
	end

	// Wait on the named lane only, keeps program order
	assign pop_go = hv[ptr];

	// Operands, x0 is never written so it reads zero
	assign src_a = regs[rs1_v[ptr]];
	assign src_b = regs[rs2_v[ptr]];
	assign mem_addr = src_a + imm_v[ptr];
	// Word index wraps in the small memory
	assign dmem_idx = mem_addr[2 +: $clog2(cpu_pkg::dmem_words)];

	always_comb
	begin
		case (op_v[ptr])
			cpu_pkg::op_add: result = src_a + src_b;
			cpu_pkg::op_addi: result = mem_addr;
			cpu_pkg::op_lw: result = dmem[dmem_idx];
			default: result = '0;
		endcase
	end

	assign writes_rd = (rd_v[ptr] != 5'd0) && ((op_v[ptr] == cpu_pkg::op_add)
		|| (op_v[ptr] == cpu_pkg::op_addi) || (op_v[ptr] == cpu_pkg::op_lw));

	// Pointer, register file and commit strobe
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			ptr <= '0;
			wb_valid <= 1'b0;
			// Registers start at zero
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else
		begin
			wb_valid <= pop_go && writes_rd;
			if (pop_go)
			begin
				ptr <= ptr + 1'b1;
				if (writes_rd)
					regs[rd_v[ptr]] <= result;
			end
		end
	end

	// Data memory and trace payload
	always_ff @(posedge clk)
	begin
		if (pop_go && op_v[ptr] == cpu_pkg::op_sw)
			dmem[dmem_idx] <= src_b;
		if (pop_go)
		begin
			wb_rd <= rd_v[ptr];
			wb_data <= result;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the piton_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_piton_core -o sim_piton_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_piton_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q ">>> FAIL" "$log"; then
	exit 1
fi
exit 0

// ==== tb_piton_core.sv ====
module tb_piton_core;

	timeunit 1ns;
	timeprecision 1ns;

	logic clk;
	logic nrst;
	logic l15_transducer_val;
	logic l15_transducer_ack;
	logic l15_transducer_header_ack;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;
	logic [3:0] l15_transducer_returntype;
	logic transducer_l15_val;
	logic [31:0] transducer_l15_address;
	logic transducer_l15_req_ack;
	logic wb_valid;
	logic [4:0] wb_rd;
	logic [31:0] wb_data;

	// Bundles as {w3, w2, w1, w0}, w0 first in program order
	logic [127:0] bundle_q [$];
	logic [4:0] exp_rd [$];
	logic [31:0] exp_data [$];

	int checks;
	int mismatches;
	int failures;
	int seen;
	bit timed_out;
	logic [31:0] rng_state;

	piton_core piton_core_inst
	(
		.clk(clk),
		.nrst(nrst),
		.l15_transducer_val(l15_transducer_val),
		.l15_transducer_ack(l15_transducer_ack),
		.l15_transducer_header_ack(l15_transducer_header_ack),
		.l15_transducer_data_0(l15_transducer_data_0),
		.l15_transducer_data_1(l15_transducer_data_1),
		.l15_transducer_returntype(l15_transducer_returntype),
		.transducer_l15_val(transducer_l15_val),
		.transducer_l15_address(transducer_l15_address),
		.transducer_l15_req_ack(transducer_l15_req_ack),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Bundle lines start with B, commit lines with C, the rest is skipped
	task automatic load_golden();
		int fd;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		fd = $fopen("piton_core_golden.txt", "r");
		if (fd == 0)
		begin
			failures++;
			$display("could not open the golden file piton_core_golden.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if ($sscanf(line, "B %h %h %h %h", a, b, c, d) == 4)
					bundle_q.push_back({d, c, b, a});
				else if ($sscanf(line, "C %h %h", a, b) == 2)
				begin
					exp_rd.push_back(a[4:0]);
					exp_data.push_back(b);
				end
			end
			$fclose(fd);
		end
		if (exp_rd.size() == 0)
		begin
			failures++;
			$display("golden file holds no expected commits");
		end
	endtask

	// Polls for a raised request, sampled mid-cycle
	task automatic await_request(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < 500; n++)
		begin
			@(negedge clk);
			if (transducer_l15_val)
			begin
				ok = 1'b1;
				break;
			end
		end
	endtask

	// Response held until the core pulses req_ack, then dropped
	task automatic hold_until_ack(output bit ok);
		int n;
		ok = 1'b0;
		for (n = 0; n < 200; n++)
		begin
			@(negedge clk);
			if (transducer_l15_req_ack)
			begin
				ok = 1'b1;
				break;
			end
		end
		@(posedge clk);
		l15_transducer_val <= 1'b0;
	endtask

	task automatic send_wakeup();
		bit ok;
		@(posedge clk);
		l15_transducer_val <= 1'b1;
		l15_transducer_returntype <= cpu_pkg::rt_wakeup;
		hold_until_ack(ok);
		if (!ok)
		begin
			failures++;
			timed_out = 1'b1;
			$display("timeout: the wake-up response was never acknowledged");
		end
	endtask

	// L1.5 model, one outstanding line load at a time
	task automatic serve_requests();
		bit ok;
		logic [127:0] line;
		logic [31:0] exp_addr;
		exp_addr = '0;
		while (!timed_out)
		begin
			await_request(ok);
			if (!ok)
			begin
				failures++;
				timed_out = 1'b1;
				$display("timeout: no request for address %h arrived", exp_addr);
			end
			else
			begin
				checks++;
				assert (transducer_l15_address == exp_addr)
				else
				begin
					mismatches++;
					$display("MISMATCH %0t: request address %h, expected %h",
						$time, transducer_l15_address, exp_addr);
				end
				exp_addr = exp_addr + 32'd16;
				// Request ack after 0 to 3 cycles
				rng_state = xorshift32(rng_state);
				repeat (rng_state[1:0]) @(posedge clk);
				@(posedge clk);
				l15_transducer_ack <= 1'b1;
				l15_transducer_header_ack <= 1'b1;
				@(posedge clk);
				l15_transducer_ack <= 1'b0;
				l15_transducer_header_ack <= 1'b0;
				// Response after another random gap
				rng_state = xorshift32(rng_state);
				repeat (rng_state[1:0]) @(posedge clk);
				// Past the end of the file only zero words, which retire as no-ops
				if (bundle_q.size() > 0)
					line = bundle_q.pop_front();
				else
					line = '0;
				@(posedge clk);
				l15_transducer_val <= 1'b1;
				l15_transducer_returntype <= cpu_pkg::rt_load_ret;
				l15_transducer_data_0 <= line[63:0];
				l15_transducer_data_1 <= line[127:64];
				hold_until_ack(ok);
				if (!ok)
				begin
					failures++;
					timed_out = 1'b1;
					$display("timeout: a load response was never acknowledged");
				end
			end
		end
	endtask

	task automatic await_commits();
		int n;
		for (n = 0; n < 4000 && !timed_out; n++)
		begin
			@(negedge clk);
			if (seen >= exp_rd.size())
				break;
		end
		if (seen < exp_rd.size())
		begin
			failures++;
			$display("timeout: only %0d of %0d expected commits arrived",
				seen, exp_rd.size());
		end
	endtask

	task automatic report_result();
		$display("checks %0d, mismatches %0d, other errors %0d",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	// Commit trace checker, one commit per pulse in golden order
	always @(negedge clk)
	begin
		if (nrst && wb_valid)
		begin
			checks++;
			assert (seen < exp_rd.size())
			else
			begin
				failures++;
				$display("an extra commit to x%0d arrived after the expected trace", wb_rd);
			end
			if (seen < exp_rd.size())
			begin
				checks++;
				assert (wb_rd == exp_rd[seen] && wb_data == exp_data[seen])
				else
				begin
					mismatches++;
					$display("MISMATCH %0t: commit %0d is x%0d=%h, expected x%0d=%h",
						$time, seen, wb_rd, wb_data, exp_rd[seen], exp_data[seen]);
				end
			end
			seen++;
		end
	end

	initial
	begin
		int n;
		nrst <= 1'b0;
		l15_transducer_val <= 1'b0;
		l15_transducer_ack <= 1'b0;
		l15_transducer_header_ack <= 1'b0;
		l15_transducer_data_0 <= '0;
		l15_transducer_data_1 <= '0;
		l15_transducer_returntype <= '0;
		checks = 0;
		mismatches = 0;
		failures = 0;
		seen = 0;
		timed_out = 1'b0;
		rng_state = 32'hbcd17f01;
		load_golden();
		repeat (8) @(posedge clk);
		nrst <= 1'b1;
		// Core stays silent until woken
		for (n = 0; n < 6; n++)
		begin
			@(negedge clk);
			checks++;
			assert (!transducer_l15_val && !transducer_l15_req_ack && !wb_valid)
			else
			begin
				failures++;
				$display("the core was active before the wake-up response");
			end
		end
		send_wakeup();
		fork
			serve_requests();
		join_none
		await_commits();
		// Trailing no-op lines must not add commits
		repeat (60) @(negedge clk);
		report_result();
	end

endmodule
